// File: common/uart_pkg.sv
////////////////////////////////////////
// UART shared definitions
////////////////////////////////////////
`default_nettype none

package uart_pkg;

    // Widths
    localparam int data_w    = 8;
    localparam int wb_data_w = 32;
    localparam int wb_addr_w = 32;

    ////////////////////////////////////////
    // Register byte offsets
    ////////////////////////////////////////
    localparam logic [7:0] reg_data      = 8'h00;
    localparam logic [7:0] reg_divisor   = 8'h04;
    localparam logic [7:0] reg_ctrl      = 8'h08;
    localparam logic [7:0] reg_rx_level  = 8'h0C;
    localparam logic [7:0] reg_tx_level  = 8'h10;
    localparam logic [7:0] reg_stop_bits = 8'h18;

    // Control and status bit positions
    localparam int ctrl_tx_empty  = 0;
    localparam int ctrl_tx_full   = 1;
    localparam int ctrl_rx_empty  = 2;
    localparam int ctrl_rx_full   = 3;
    localparam int ctrl_parity_en = 4;
    localparam int ctrl_overrun   = 5;

    // Baud divisor out of reset
    localparam logic [wb_data_w-1:0] divisor_reset = 15;

    // Received character with parity_err at bit 8
    typedef struct packed {
        logic              parity_err;
        logic [data_w-1:0] data;
    } rx_frame_t;

endpackage

`default_nettype wire

// File: hdl/uart_fifo.sv
////////////////////////////////////////
// Synchronous FIFO
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter int  depth     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  payload_t               push_data,
    input  logic                   pop,
    output payload_t               head,
    output logic                   empty,
    output logic                   full,
    output logic [$clog2(depth):0] level,
    output logic                   credit_return
);

    localparam int aw = $clog2(depth);

    payload_t       mem [depth];
    logic [aw:0]    wr_ptr;
    logic [aw:0]    rd_ptr;
    logic           do_push;
    logic           do_pop;

    // Wrap bit tells full from empty
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign level   = wr_ptr - rd_ptr;
    assign head    = mem[rd_ptr[aw-1:0]];
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[aw-1:0]] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // One credit back per real pop
            credit_return <= do_pop;
        end
    end

    // Producer and consumer must honour the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) full |-> !push);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

`default_nettype wire

// File: tx/uart_tx.sv
////////////////////////////////////////
// UART transmit serializer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [uart_pkg::wb_data_w-1:0]  divisor,
    input  logic                            parity_en,
    input  logic [7:0]                      stop_bits,
    input  logic                            tx_empty,
    input  logic [uart_pkg::data_w-1:0]     tx_head,
    output logic                            tx_pop,
    output logic                            tx
);

    import uart_pkg::*;

    typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} tx_state_t;

    tx_state_t            state;
    logic [wb_data_w-1:0] cnt;
    logic [7:0]           bit_cnt;
    logic [data_w-1:0]    shift;
    logic [data_w-1:0]    data_q;
    logic                 bit_done;
    logic [7:0]           stop_last;
    logic                 line_bit;

    assign bit_done  = (cnt == divisor);
    assign stop_last = (stop_bits == 8'd0) ? 8'd0 : stop_bits - 8'd1;
    // Byte leaves the FIFO as it is loaded
    assign tx_pop    = (state == st_idle) && !tx_empty;

    always_comb
    begin
        case (state)
            st_start:  line_bit = 1'b0;
            st_data:   line_bit = shift[0];
            st_parity: line_bit = ~^data_q;
            default:   line_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= st_idle;
            cnt     <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end
        else
        begin
            tx  <= line_bit;
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                st_idle:
                begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (!tx_empty)
                        state <= st_start;
                end
                st_start:
                    if (bit_done)
                        state <= st_data;
                st_data:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 8'd7)
                        begin
                            bit_cnt <= '0;
                            state   <= parity_en ? st_parity : st_stop;
                        end
                    end
                st_parity:
                    if (bit_done)
                        state <= st_stop;
                st_stop:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt >= stop_last)
                            state <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Shift register and the byte kept for parity
    always_ff @(posedge clk)
    begin
        if (tx_pop)
        begin
            shift  <= tx_head;
            data_q <= tx_head;
        end
        else if (state == st_data && bit_done)
            shift <= shift >> 1;
    end

endmodule

`default_nettype wire

// File: rx/uart_rx.sv
////////////////////////////////////////
// UART receive deserializer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int depth = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rx,
    input  logic [uart_pkg::wb_data_w-1:0]  divisor,
    input  logic                            parity_en,
    input  logic [7:0]                      stop_bits,
    input  logic                            credit_return,
    output logic                            rx_push,
    output uart_pkg::rx_frame_t             rx_push_frame,
    output logic                            overrun_set
);

    import uart_pkg::*;

    localparam int crd_w = $clog2(depth) + 1;

    typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [wb_data_w-1:0] cnt;
    logic [7:0]           bit_cnt;
    logic [data_w-1:0]    shift;
    logic                 perr;
    logic [crd_w-1:0]     credit;
    logic                 bit_done;
    logic                 half_done;
    logic [7:0]           stop_last;
    logic                 frame_end;
    logic                 take;

    assign bit_done  = (cnt == divisor);
    assign half_done = (cnt == (divisor >> 1));
    assign stop_last = (stop_bits == 8'd0) ? 8'd0 : stop_bits - 8'd1;
    // Middle of the last stop bit
    assign frame_end = (state == st_stop) && bit_done && (bit_cnt >= stop_last);
    assign take      = frame_end && (credit != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            cnt         <= '0;
            bit_cnt     <= '0;
            rx_push     <= 1'b0;
            overrun_set <= 1'b0;
        end
        else
        begin
            rx_push     <= take;
            overrun_set <= frame_end && !take;
            cnt         <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                st_idle:
                begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (rx_prev && !rx_sync)
                        state <= st_start;
                end
                st_start:
                    if (half_done)
                    begin
                        // Still low half a bit on, otherwise a glitch
                        cnt   <= '0;
                        state <= rx_sync ? st_idle : st_data;
                    end
                st_data:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 8'd7)
                        begin
                            bit_cnt <= '0;
                            state   <= parity_en ? st_parity : st_stop;
                        end
                    end
                st_parity:
                    if (bit_done)
                        state <= st_stop;
                st_stop:
                    if (bit_done)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (frame_end)
                            state <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_start)
            perr <= 1'b0;
        if (state == st_data && bit_done)
            shift <= {rx_sync, shift[data_w-1:1]};
        // Odd parity over data and parity bit
        if (state == st_parity && bit_done)
            perr <= ~^{shift, rx_sync};
        if (frame_end)
        begin
            rx_push_frame.data       <= shift;
            rx_push_frame.parity_err <= perr;
        end
    end

    // One credit per free RX FIFO entry
    always_ff @(posedge clk)
    begin
        if (rst)
            credit <= crd_w'(depth);
        else if (take && !credit_return)
            credit <= credit - 1'b1;
        else if (!take && credit_return)
            credit <= credit + 1'b1;
    end

    a_credit_max: assert property (@(posedge clk) disable iff (rst) credit <= crd_w'(depth));

endmodule

`default_nettype wire

// File: hdl/uart_wb_regs.sv
////////////////////////////////////////
// UART register slave
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_wb_regs #(
    parameter int depth = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [uart_pkg::wb_addr_w-1:0]  wb_adr,
    input  logic [uart_pkg::wb_data_w-1:0]  wb_dat_w,
    output logic [uart_pkg::wb_data_w-1:0]  wb_dat_r,
    output logic                            wb_ack,
    input  logic                            tx_full,
    input  logic                            tx_empty,
    input  logic [$clog2(depth):0]          tx_level,
    output logic                            tx_push,
    output logic [uart_pkg::data_w-1:0]     tx_push_data,
    input  logic                            rx_empty,
    input  logic                            rx_full,
    input  logic [$clog2(depth):0]          rx_level,
    input  uart_pkg::rx_frame_t             rx_head,
    output logic                            rx_pop,
    input  logic                            overrun_set,
    output logic [uart_pkg::wb_data_w-1:0]  divisor,
    output logic                            parity_en,
    output logic [7:0]                      stop_bits
);

    import uart_pkg::*;

    typedef enum logic {st_idle, st_ack} bus_state_t;

    bus_state_t           state;
    logic                 req;
    logic                 is_data;
    logic                 accept;
    logic [7:0]           offset;
    logic                 overrun;
    logic [wb_data_w-1:0] status;
    logic [wb_data_w-1:0] rd_word;

    assign req     = wb_cyc && wb_stb && (state == st_idle);
    assign offset  = wb_adr[7:0];
    assign is_data = (offset == reg_data);

    // Data accesses block on the FIFO flags
    assign accept       = req && (!is_data || (wb_we ? !tx_full : !rx_empty));
    assign tx_push      = accept && wb_we && is_data;
    assign tx_push_data = wb_dat_w[data_w-1:0];
    assign rx_pop       = accept && !wb_we && is_data;

    always_comb
    begin
        status                 = '0;
        status[ctrl_tx_empty]  = tx_empty;
        status[ctrl_tx_full]   = tx_full;
        status[ctrl_rx_empty]  = rx_empty;
        status[ctrl_rx_full]   = rx_full;
        status[ctrl_parity_en] = parity_en;
        status[ctrl_overrun]   = overrun;
    end

    always_comb
    begin
        case (offset)
            reg_data:      rd_word = wb_data_w'(rx_head);
            reg_divisor:   rd_word = divisor;
            reg_ctrl:      rd_word = status;
            reg_rx_level:  rd_word = wb_data_w'(rx_level);
            reg_tx_level:  rd_word = wb_data_w'(tx_level);
            reg_stop_bits: rd_word = wb_data_w'(stop_bits);
            default:       rd_word = '0;
        endcase
    end

    ////////////////////////////////////////
    // Bus FSM and configuration
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            wb_ack    <= 1'b0;
            divisor   <= divisor_reset;
            parity_en <= 1'b0;
            stop_bits <= 8'd1;
            overrun   <= 1'b0;
        end
        else
        begin
            wb_ack <= accept;
            state  <= accept ? st_ack : st_idle;
            if (accept && wb_we)
            begin
                case (offset)
                    reg_divisor:   divisor <= wb_dat_w;
                    reg_ctrl:      parity_en <= wb_dat_w[ctrl_parity_en];
                    reg_stop_bits: stop_bits <= wb_dat_w[7:0];
                    default:       ;
                endcase
            end
            // Sticky overrun where a new overrun beats the clear
            if (overrun_set)
                overrun <= 1'b1;
            else if (accept && wb_we && offset == reg_ctrl && wb_dat_w[ctrl_overrun])
                overrun <= 1'b0;
        end
    end

    // Read data is captured with the pop
    always_ff @(posedge clk)
    begin
        wb_dat_r <= (accept && !wb_we) ? rd_word : '0;
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// File: hdl/uart_top.sv
////////////////////////////////////////
// UART peripheral top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int fifo_depth = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [uart_pkg::wb_addr_w-1:0]  wb_adr,
    input  logic [uart_pkg::wb_data_w-1:0]  wb_dat_w,
    output logic [uart_pkg::wb_data_w-1:0]  wb_dat_r,
    output logic                            wb_ack,
    input  logic                            rx,
    output logic                            tx
);

    import uart_pkg::*;

    localparam int lvl_w = $clog2(fifo_depth) + 1;

    // TX path
    logic              tx_push;
    logic [data_w-1:0] tx_push_data;
    logic              tx_pop;
    logic [data_w-1:0] tx_head;
    logic              tx_empty;
    logic              tx_full;
    logic [lvl_w-1:0]  tx_level;

    // RX path
    logic              rx_push;
    rx_frame_t         rx_push_frame;
    logic              rx_pop;
    rx_frame_t         rx_head;
    logic              rx_empty;
    logic              rx_full;
    logic [lvl_w-1:0]  rx_level;
    logic              credit_return;

    // Configuration
    logic [wb_data_w-1:0] divisor;
    logic                 parity_en;
    logic [7:0]           stop_bits;
    logic                 overrun_set;

    uart_wb_regs #(.depth(fifo_depth)) u_wb_regs (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .tx_full, .tx_empty, .tx_level, .tx_push, .tx_push_data,
        .rx_empty, .rx_full, .rx_level, .rx_head, .rx_pop,
        .overrun_set, .divisor, .parity_en, .stop_bits
    );

    uart_fifo #(.depth(fifo_depth), .payload_t(logic [data_w-1:0])) u_tx_fifo (
        .clk, .rst,
        .push(tx_push), .push_data(tx_push_data), .pop(tx_pop), .head(tx_head),
        .empty(tx_empty), .full(tx_full), .level(tx_level), .credit_return()
    );

    uart_fifo #(.depth(fifo_depth), .payload_t(rx_frame_t)) u_rx_fifo (
        .clk, .rst,
        .push(rx_push), .push_data(rx_push_frame), .pop(rx_pop), .head(rx_head),
        .empty(rx_empty), .full(rx_full), .level(rx_level), .credit_return
    );

    uart_tx u_tx (
        .clk, .rst, .divisor, .parity_en, .stop_bits,
        .tx_empty, .tx_head, .tx_pop, .tx
    );

    uart_rx #(.depth(fifo_depth)) u_rx (
        .clk, .rst, .rx, .divisor, .parity_en, .stop_bits,
        .credit_return, .rx_push, .rx_push_frame, .overrun_set
    );

endmodule

`default_nettype wire

// File: tb/uart_tb_ref.svh
////////////////////////////////////////
// UART testbench bus and line helpers
////////////////////////////////////////
`ifndef UART_TB_REF_SVH
`define UART_TB_REF_SVH

// Parity bit that makes the ones count odd
function automatic logic odd_parity_bit(input logic [7:0] data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++)
        ones += data[i];
    // An even count of data ones needs a one here
    return (ones % 2 == 0);
endfunction

// Line bits of one frame with bit 0 first
function automatic logic [31:0] frame_bits(input logic [7:0] data, input logic par);
    logic [31:0] bits;
    int          i;
    // Stop bits and unused tail stay high
    bits    = '1;
    bits[0] = 1'b0;
    for (i = 0; i < 8; i++)
        bits[1 + i] = data[i];
    if (par)
        bits[9] = odd_parity_bit(data);
    return bits;
endfunction

function automatic int frame_len(input logic par, input int stops);
    return 9 + (par ? 1 : 0) + ((stops < 1) ? 1 : stops);
endfunction

task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = {24'h0, addr};
    wb_dat_w = data;
    n        = 0;
    do
    begin
        @(posedge clk);
        #1;
        n++;
    end
    while (!wb_ack && n < bus_timeout);
    assert (wb_ack) else stop_on_error("write got no wb_ack before the timeout");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = {24'h0, addr};
    n      = 0;
    do
    begin
        @(posedge clk);
        #1;
        n++;
    end
    while (!wb_ack && n < bus_timeout);
    assert (wb_ack) else stop_on_error("read got no wb_ack before the timeout");
    // Read data is valid in the ack cycle
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

// Drive one frame on the rx pin, then one idle bit time
task automatic send_frame(input logic [7:0] data, input logic par, input int stops,
                          input logic flip);
    logic [31:0] bits;
    int          len;
    int          i;
    bits = frame_bits(data, par);
    len  = frame_len(par, stops);
    if (par && flip)
        bits[9] = ~bits[9];
    @(posedge clk);
    #1;
    for (i = 0; i < len; i++)
    begin
        rx = bits[i];
        repeat (bit_cycles) @(posedge clk);
        #1;
    end
    rx = 1'b1;
    repeat (bit_cycles) @(posedge clk);
    #1;
endtask

`endif

// File: tb/uart_tb.sv
////////////////////////////////////////
// UART testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    import uart_pkg::*;

    localparam int fifo_depth    = 8;
    localparam int bus_timeout   = 2000;
    localparam int drain_timeout = 20000;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        rx;
    logic        tx;

    int          bit_cycles;
    logic        cfg_parity;
    int          cfg_stops;
    int          errors;
    logic [31:0] exp_bits_q[$];
    int          exp_len_q[$];

    task automatic stop_on_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    `include "uart_tb_ref.svh"

    uart_top #(.fifo_depth(fifo_depth)) u_uart_top (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
        .wb_ack, .rx, .tx
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
            stop_on_error($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    // Queue the expected line frame, then hand the byte to the TX FIFO
    task automatic write_tx_byte(input logic [7:0] data);
        exp_bits_q.push_back(frame_bits(data, cfg_parity));
        exp_len_q.push_back(frame_len(cfg_parity, cfg_stops));
        bus_write(reg_data, {24'h0, data});
    endtask

    task automatic wait_tx_drained;
        int n;
        n = 0;
        while (exp_len_q.size() != 0 && n < drain_timeout)
        begin
            @(posedge clk);
            n++;
        end
        assert (exp_len_q.size() == 0) else stop_on_error("tx frames did not all appear");
        // Let the last stop bits finish
        repeat (4 * bit_cycles) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // TX line comparison
    ////////////////////////////////////////
    initial
    begin : tx_monitor
        logic [31:0] exp_bits;
        int          exp_len;
        int          idle_cycles;
        int          i;
        idle_cycles = 0;
        forever
        begin
            @(negedge clk);
            if (tx === 1'b0)
            begin
                assert (exp_len_q.size() != 0)
                else
                    stop_on_error("start bit on tx with no frame expected");
                exp_bits = exp_bits_q[0];
                exp_len  = exp_len_q[0];
                // Middle of the start bit
                repeat (bit_cycles / 2) @(negedge clk);
                for (i = 0; i < exp_len; i++)
                begin
                    assert (tx === exp_bits[i])
                    else
                        stop_on_error($sformatf("[ERROR] tx bit %0d got 0x%0h expected 0x%0h",
                                                i, tx, exp_bits[i]));
                    if (i < exp_len - 1)
                        repeat (bit_cycles) @(negedge clk);
                end
                void'(exp_bits_q.pop_front());
                void'(exp_len_q.pop_front());
                idle_cycles = 0;
            end
            else if (exp_len_q.size() != 0)
            begin
                idle_cycles++;
                assert (idle_cycles < 20 * bit_cycles)
                else
                    stop_on_error("tx stayed idle while a frame was expected");
            end
            else
                idle_cycles = 0;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin : sequence_main
        logic [31:0] rd;
        logic [7:0]  sent[9];
        logic        flip;
        int          i;
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        rx          = 1'b1;
        bit_cycles  = 16;
        cfg_parity  = 1'b0;
        cfg_stops   = 1;
        errors      = 0;
        void'($urandom(32'hd0a4cf1f));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset values and readback
        bus_read(reg_ctrl, rd);
        check_value("status", rd, 32'h05);
        bus_read(reg_divisor, rd);
        check_value("divisor", rd, 32'd15);
        bus_read(reg_stop_bits, rd);
        check_value("stop_bits", rd, 32'd1);
        bus_read(8'h14, rd);
        check_value("unmapped 0x14", rd, 32'h0);
        bus_read(8'h1C, rd);
        check_value("unmapped 0x1c", rd, 32'h0);
        bus_write(8'h14, 32'hFFFF_FFFF);
        bus_write(reg_divisor, 32'd7);
        bit_cycles = 8;
        bus_read(reg_divisor, rd);
        check_value("divisor", rd, 32'd7);
        bus_write(reg_ctrl, 32'h10);
        bus_read(reg_ctrl, rd);
        check_value("status", rd, 32'h15);
        bus_write(reg_stop_bits, 32'd2);
        bus_read(reg_stop_bits, rd);
        check_value("stop_bits", rd, 32'd2);

        // TX with parity off and one stop bit
        bus_write(reg_ctrl, 32'h00);
        bus_write(reg_stop_bits, 32'd1);
        cfg_parity = 1'b0;
        cfg_stops  = 1;
        for (i = 0; i < 6; i++)
            write_tx_byte(8'($urandom));
        wait_tx_drained();

        // TX with parity on and two stop bits
        bus_write(reg_ctrl, 32'h10);
        bus_write(reg_stop_bits, 32'd2);
        cfg_parity = 1'b1;
        cfg_stops  = 2;
        for (i = 0; i < 6; i++)
            write_tx_byte(8'($urandom));
        wait_tx_drained();
        bus_read(reg_tx_level, rd);
        check_value("tx_level", rd, 32'd0);

        // RX with good then flipped parity
        bus_write(reg_stop_bits, 32'd1);
        cfg_stops = 1;
        for (i = 0; i < 8; i++)
        begin
            flip    = (i >= 4);
            sent[0] = 8'($urandom);
            send_frame(sent[0], 1'b1, cfg_stops, flip);
            bus_read(reg_data, rd);
            check_value("rx data", rd, {23'h0, flip, sent[0]});
        end

        // RX level and empty flag
        for (i = 0; i < 3; i++)
        begin
            sent[i] = 8'($urandom);
            send_frame(sent[i], 1'b1, cfg_stops, 1'b0);
        end
        bus_read(reg_rx_level, rd);
        check_value("rx_level", rd, 32'd3);
        bus_read(reg_ctrl, rd);
        check_value("rx_empty", rd[ctrl_rx_empty], 32'd0);
        for (i = 0; i < 3; i++)
        begin
            bus_read(reg_data, rd);
            check_value("rx data", rd, {24'h0, sent[i]});
        end
        bus_read(reg_ctrl, rd);
        check_value("rx_empty", rd[ctrl_rx_empty], 32'd1);
        bus_read(reg_rx_level, rd);
        check_value("rx_level", rd, 32'd0);

        // Nine frames into eight credits
        for (i = 0; i < 9; i++)
        begin
            sent[i] = 8'($urandom);
            send_frame(sent[i], 1'b1, cfg_stops, 1'b0);
        end
        bus_read(reg_ctrl, rd);
        check_value("rx_full", rd[ctrl_rx_full], 32'd1);
        check_value("overrun", rd[ctrl_overrun], 32'd1);
        for (i = 0; i < 8; i++)
        begin
            bus_read(reg_data, rd);
            check_value("rx data", rd, {24'h0, sent[i]});
        end
        bus_write(reg_ctrl, 32'h30);
        bus_read(reg_ctrl, rd);
        check_value("status", rd, 32'h15);

        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
common/uart_pkg.sv
hdl/uart_fifo.sv
tx/uart_tx.sv
rx/uart_rx.sv
hdl/uart_wb_regs.sv
hdl/uart_top.sv
tb/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - common/uart_pkg.sv
  - hdl/uart_fifo.sv
  - tx/uart_tx.sv
  - rx/uart_rx.sv
  - hdl/uart_wb_regs.sv
  - hdl/uart_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/uart_tb.sv
